/* include/dbg_cfg.svh */
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Debug dump frame and serial line settings
////////////////////////////////////////////////////////////////////////////

// Bytes per frame: 4 sync, 128 register, 4 control
`define DBG_FRAME_LEN 136

// Value of each of the four leading header bytes
`define DBG_SYNC_BYTE 8'hA5

// Clock cycles per serial bit, any value of 2 or more
// Kept at 4 so simulation runs short
`define DBG_BIT_CYCLES 4

`endif

/* design/dbg_pkg.sv */
package dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types shared by the dump unit
  ////////////////////////////////////////////////////////////////////////////

  // One byte of the serial frame
  typedef logic [7:0] byte_t;

  // One MIPS general register
  typedef logic [31:0] word_t;

  // Whole register file, register 0 sits at index 0
  typedef word_t [31:0] regfile_t;

  // Read pointer into the 136-byte frame
  typedef logic [7:0] frame_idx_t;

endpackage

/* design/dbg_snapshot_buf.sv */
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_snapshot_buf
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              capture,        // Load the whole frame
  input  logic              rd,             // Advance to next byte
  input  dbg_pkg::regfile_t regs,           // Register file contents
  input  logic [1:0]        reg_dst_id,     // ID/EX two-bit controls
  input  logic [1:0]        memto_reg_id,
  input  logic [1:0]        alu_op_id,
  input  logic              branch_id,      // ID/EX one-bit controls
  input  logic              mem_read_id,
  input  logic              mem_write_id,
  input  logic              alu_src_id,
  input  logic              reg_write_id,
  input  logic              mem_read_ex,    // EX stage controls
  input  logic              mem_write_ex,
  input  logic              reg_write_ex,
  input  logic [1:0]        memto_reg_ex,
  input  logic              reg_write_mem,  // MEM stage controls
  input  logic [1:0]        memto_reg_mem,
  output logic              empty,          // No byte left to read
  output dbg_pkg::byte_t    r_data          // Byte at read pointer
);

  dbg_pkg::byte_t     frame_mem [0:`DBG_FRAME_LEN-1]; // Snapshot storage
  dbg_pkg::frame_idx_t rd_ptr;                         // Next byte to serve
  logic               empty_q;
  logic               last_byte;

  ////////////////////////////////////////////////////////////////////////////
  // Frame capture, all bytes written on one edge
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      for (int s = 0; s < 4; s++)
      begin
        frame_mem[s] <= `DBG_SYNC_BYTE;                 // Sync header
      end
      for (int r = 0; r < 32; r++)
      begin
        for (int b = 0; b < 4; b++)
        begin
          frame_mem[4 + 4*r + b] <= regs[r][8*(3-b) +: 8]; // MSB first
        end
      end
      frame_mem[132] <= {2'b00, reg_dst_id, memto_reg_id, alu_op_id};
      frame_mem[133] <= {3'b101, branch_id, mem_read_id, mem_write_id,
                         alu_src_id, reg_write_id};      // ID/EX one-bit flags
      frame_mem[134] <= {3'b010, mem_read_ex, mem_write_ex, reg_write_ex,
                         memto_reg_ex};                  // EX stage
      frame_mem[135] <= {5'b00110, reg_write_mem, memto_reg_mem}; // MEM stage
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read pointer and empty flag
  ////////////////////////////////////////////////////////////////////////////

  assign last_byte = (rd_ptr == dbg_pkg::frame_idx_t'(`DBG_FRAME_LEN - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_ptr  <= '0;
      empty_q <= 1'b1;                                   // Nothing captured yet
    end
    else if (capture)
    begin
      rd_ptr  <= '0;                                     // Restart at sync byte
      empty_q <= 1'b0;
    end
    else if (rd && !empty_q)
    begin
      if (last_byte)
        empty_q <= 1'b1;                                 // Byte 135 consumed
      else
        rd_ptr <= rd_ptr + 8'd1;
    end
  end

  assign r_data = frame_mem[rd_ptr];                     // Combinational read
  assign empty  = empty_q;

  // Controller only reads a loaded frame
  a_no_rd_empty : assert property (@(posedge clk) disable iff (!rst_n)
    rd |-> !empty_q);

  // A new capture waits until the old frame has gone out
  a_no_cap_busy : assert property (@(posedge clk) disable iff (!rst_n)
    capture |-> empty_q);

endmodule

/* design/dbg_uart_tx.sv */
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_uart_tx
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           tx_start,  // Latch tx_data and begin a frame
  input  dbg_pkg::byte_t tx_data,   // Byte to send
  output logic           txd,       // Serial line, idles high
  output logic           tx_busy    // High while a frame is on the line
);

  localparam int CNT_W = $clog2(`DBG_BIT_CYCLES); // Bit-period counter width

  logic [9:0]       shift_q;   // Stop, data, start from MSB to LSB
  logic [CNT_W-1:0] cyc_cnt;   // Cycles spent in current bit
  logic [3:0]       bit_cnt;   // Bits already sent, 0 to 9
  logic             busy_q;
  logic             bit_end;   // Last cycle of current bit

  ////////////////////////////////////////////////////////////////////////////
  // Bit timing and shift register
  ////////////////////////////////////////////////////////////////////////////

  assign bit_end = (cyc_cnt == CNT_W'(`DBG_BIT_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q <= '1;                                // Line held at mark
      cyc_cnt <= '0;
      bit_cnt <= '0;
      busy_q  <= 1'b0;
    end
    else if (tx_start && !busy_q)
    begin
      shift_q <= {1'b1, tx_data, 1'b0};             // 8N1 frame, LSB first
      cyc_cnt <= '0;
      bit_cnt <= '0;
      busy_q  <= 1'b1;
    end
    else if (busy_q)
    begin
      if (bit_end)
      begin
        cyc_cnt <= '0;
        shift_q <= {1'b1, shift_q[9:1]};            // Next bit, refill with mark
        if (bit_cnt == 4'd9)
        begin
          bit_cnt <= '0;
          busy_q  <= 1'b0;                          // Stop bit finished
        end
        else
        begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
      else
      begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  assign txd     = shift_q[0];                      // Idle shift reg is all ones
  assign tx_busy = busy_q;

  // Controller must wait out the current frame
  a_no_start_busy : assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !busy_q);

endmodule

/* design/dbg_dump_ctrl.sv */
`timescale 1ns/1ps

module dbg_dump_ctrl
(
  input  logic clk,
  input  logic rst_n,
  input  logic dump_req,  // One-cycle dump request
  input  logic empty,     // Buffer has no byte left
  input  logic tx_busy,   // Transmitter sending
  output logic capture,   // Load snapshot into buffer
  output logic rd,        // Pop byte from buffer
  output logic tx_start,  // Start transmitter on current byte
  output logic busy,      // Dump in progress
  output logic done       // Last stop bit has ended
);

  typedef enum logic [2:0] {ST_IDLE, ST_LOAD, ST_SEND, ST_WAIT, ST_DRAIN} state_t;

  state_t state_q;
  state_t state_d;
  logic   send_ok;        // Byte ready and line free

  ////////////////////////////////////////////////////////////////////////////
  // Dump sequencing FSM
  ////////////////////////////////////////////////////////////////////////////

  assign send_ok = (state_q == ST_SEND) && !empty && !tx_busy;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE  : if (dump_req) state_d = ST_LOAD;  // Requests while busy dropped
      ST_LOAD  : state_d = ST_SEND;                // Capture happens here
      ST_SEND  :
      begin
        if (empty)
          state_d = ST_DRAIN;                      // Frame fully handed over
        else if (send_ok)
          state_d = ST_WAIT;
      end
      ST_WAIT  : state_d = ST_SEND;                // Let tx_busy rise
      ST_DRAIN : if (!tx_busy) state_d = ST_IDLE;  // Last byte on the wire
      default  : state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  assign capture  = (state_q == ST_LOAD);
  assign tx_start = send_ok;                       // Latch and pop together
  assign rd       = send_ok;
  assign busy     = (state_q != ST_IDLE);
  assign done     = (state_q == ST_DRAIN) && !tx_busy;

  // SEND must find the fresh frame right after the capture cycle
  a_cap_fill : assert property (@(posedge clk) disable iff (!rst_n)
    capture |=> !empty);

endmodule

/* design/dbg_dump_top.sv */
`timescale 1ns/1ps

module dbg_dump_top
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dump_req,       // Request one frame
  input  dbg_pkg::regfile_t regs,           // Register file contents
  input  logic [1:0]        reg_dst_id,     // ID/EX controls
  input  logic [1:0]        memto_reg_id,
  input  logic [1:0]        alu_op_id,
  input  logic              branch_id,
  input  logic              mem_read_id,
  input  logic              mem_write_id,
  input  logic              alu_src_id,
  input  logic              reg_write_id,
  input  logic              mem_read_ex,    // EX controls
  input  logic              mem_write_ex,
  input  logic              reg_write_ex,
  input  logic [1:0]        memto_reg_ex,
  input  logic              reg_write_mem,  // MEM controls
  input  logic [1:0]        memto_reg_mem,
  output logic              txd,            // UART line
  output logic              busy,           // Dump running
  output logic              done            // Frame finished
);

  logic           capture;
  logic           rd;
  logic           empty;
  logic           tx_start;
  logic           tx_busy;
  dbg_pkg::byte_t r_data;   // Buffer byte feeding the transmitter

  ////////////////////////////////////////////////////////////////////////////
  // Snapshot buffer, controller and UART
  ////////////////////////////////////////////////////////////////////////////

  dbg_snapshot_buf buf_i (
    .clk          (clk),          .rst_n         (rst_n),
    .capture      (capture),      .rd            (rd),
    .regs         (regs),
    .reg_dst_id   (reg_dst_id),   .memto_reg_id  (memto_reg_id),
    .alu_op_id    (alu_op_id),    .branch_id     (branch_id),
    .mem_read_id  (mem_read_id),  .mem_write_id  (mem_write_id),
    .alu_src_id   (alu_src_id),   .reg_write_id  (reg_write_id),
    .mem_read_ex  (mem_read_ex),  .mem_write_ex  (mem_write_ex),
    .reg_write_ex (reg_write_ex), .memto_reg_ex  (memto_reg_ex),
    .reg_write_mem(reg_write_mem), .memto_reg_mem(memto_reg_mem),
    .empty        (empty),        .r_data        (r_data)
  );

  dbg_dump_ctrl ctrl_i (
    .clk     (clk),      .rst_n   (rst_n),
    .dump_req(dump_req), .empty   (empty),
    .tx_busy (tx_busy),  .capture (capture),
    .rd      (rd),       .tx_start(tx_start),
    .busy    (busy),     .done    (done)
  );

  dbg_uart_tx tx_i (
    .clk     (clk),      .rst_n   (rst_n),
    .tx_start(tx_start), .tx_data (r_data),  // Byte latched as pointer moves
    .txd     (txd),      .tx_busy (tx_busy)
  );

endmodule

/* bench/dbg_dump_tb.sv */
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_dump_tb;

  localparam int NUM_DUMPS       = 4;
  localparam int WATCHDOG_CYCLES = NUM_DUMPS * `DBG_FRAME_LEN * 10 * `DBG_BIT_CYCLES * 2
                                   + 1000;        // Four frames at half speed, plus slack

  logic              clk;
  logic              rst_n;
  logic              dump_req;
  dbg_pkg::regfile_t regs;
  logic [1:0]        reg_dst_id;
  logic [1:0]        memto_reg_id;
  logic [1:0]        alu_op_id;
  logic              branch_id;
  logic              mem_read_id;
  logic              mem_write_id;
  logic              alu_src_id;
  logic              reg_write_id;
  logic              mem_read_ex;
  logic              mem_write_ex;
  logic              reg_write_ex;
  logic [1:0]        memto_reg_ex;
  logic              reg_write_mem;
  logic [1:0]        memto_reg_mem;
  logic              txd;
  logic              busy;
  logic              done;

  dbg_pkg::regfile_t nxt_regs;                    // Values driven on the latest edge
  logic [18:0]       nxt_ctrl;                    // All control bits, same edge
  dbg_pkg::byte_t    exp_q [$];                   // Model bytes not yet received
  int                rx_count;                    // Bytes seen on txd
  int                done_count;                  // done pulses seen
  int unsigned       seed;
  int                d;
  logic              got_done;

  dbg_dump_top dut_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Error reporting and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task stop_on_error(string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task mismatch(string name, logic [31:0] got, logic [31:0] exp);
    stop_on_error($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task check_idle_outputs();
    assert (txd === 1'b1) else mismatch("txd", txd, 1);     // Line at mark
    assert (busy === 1'b0) else mismatch("busy", busy, 0);
    assert (done === 1'b0) else mismatch("done", done, 0);
  endtask

  task drive_random_state();
    int r;
    for (r = 0; r < 32; r++)
      nxt_regs[r] = $urandom;
    nxt_ctrl = 19'($urandom);
    regs          <= nxt_regs;
    reg_dst_id    <= nxt_ctrl[1:0];              // ID/EX fields
    memto_reg_id  <= nxt_ctrl[3:2];
    alu_op_id     <= nxt_ctrl[5:4];
    branch_id     <= nxt_ctrl[6];
    mem_read_id   <= nxt_ctrl[7];
    mem_write_id  <= nxt_ctrl[8];
    alu_src_id    <= nxt_ctrl[9];
    reg_write_id  <= nxt_ctrl[10];
    mem_read_ex   <= nxt_ctrl[11];               // EX fields
    mem_write_ex  <= nxt_ctrl[12];
    reg_write_ex  <= nxt_ctrl[13];
    memto_reg_ex  <= nxt_ctrl[15:14];
    reg_write_mem <= nxt_ctrl[16];               // MEM fields
    memto_reg_mem <= nxt_ctrl[18:17];
  endtask

  // Frame model built from the values that sit on the inputs during capture
  task push_expected_frame();
    dbg_pkg::frame_idx_t idx;
    dbg_pkg::word_t      w;
    dbg_pkg::byte_t      fb;
    for (idx = 0; idx < `DBG_FRAME_LEN; idx++)
    begin
      if (idx < 4)
        fb = `DBG_SYNC_BYTE;                     // Header
      else if (idx < 132)
      begin
        w  = nxt_regs[(idx - 4) / 4];
        fb = w[31 - 8 * ((idx - 4) % 4) -: 8];   // Top byte of each register first
      end
      else
      begin
        case (idx)
          132:     fb = {2'b00, nxt_ctrl[1:0], nxt_ctrl[3:2], nxt_ctrl[5:4]};
          133:     fb = {3'b101, nxt_ctrl[6], nxt_ctrl[7], nxt_ctrl[8], nxt_ctrl[9],
                         nxt_ctrl[10]};
          134:     fb = {3'b010, nxt_ctrl[11], nxt_ctrl[12], nxt_ctrl[13], nxt_ctrl[15:14]};
          default: fb = {5'b00110, nxt_ctrl[16], nxt_ctrl[18:17]};
        endcase
      end
      exp_q.push_back(fb);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, watchdog and monitors
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;                      // 40 ns period
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_on_error("Timeout: the dumps did not finish within the expected time");
  end

  // Serial receiver, samples near the middle of each bit on falling clock
  initial
  begin : uart_receiver
    dbg_pkg::byte_t rx_byte;
    dbg_pkg::byte_t exp_byte;
    int             k;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge txd);
      repeat ((`DBG_BIT_CYCLES + 1) / 2) @(negedge clk);
      assert (txd === 1'b0) else mismatch("txd start bit", txd, 0);
      for (k = 0; k < 8; k++)
      begin
        repeat (`DBG_BIT_CYCLES) @(negedge clk);
        rx_byte[k] = txd;                        // LSB first
      end
      repeat (`DBG_BIT_CYCLES) @(negedge clk);
      assert (txd === 1'b1) else mismatch("txd stop bit", txd, 1);
      if (exp_q.size() == 0)
        stop_on_error("A byte arrived on txd while no frame was expected");
      else
      begin
        exp_byte = exp_q.pop_front();
        assert (rx_byte === exp_byte)
          else mismatch($sformatf("txd byte %0d", rx_count % `DBG_FRAME_LEN),
                        rx_byte, exp_byte);
        rx_count++;
      end
    end
  end

  // done must come once per frame, after its last stop bit
  initial
  begin : done_monitor
    forever
    begin
      @(negedge clk);
      if (rst_n === 1'b1 && done === 1'b1)
      begin
        done_count++;
        assert (busy === 1'b1) else mismatch("busy", busy, 1);
        assert (rx_count == done_count * `DBG_FRAME_LEN)
          else mismatch("rx_count", rx_count, done_count * `DBG_FRAME_LEN);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    seed = 32'hd0d247a0;
    void'($urandom(seed));
    rx_count   = 0;
    done_count = 0;
    rst_n      = 1'b0;
    dump_req   = 1'b0;
    nxt_regs   = '0;
    nxt_ctrl   = '0;
    regs       = '0;
    {reg_dst_id, memto_reg_id, alu_op_id, branch_id, mem_read_id} = '0;
    {mem_write_id, alu_src_id, reg_write_id, mem_read_ex, mem_write_ex} = '0;
    {reg_write_ex, memto_reg_ex, reg_write_mem, memto_reg_mem} = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (10)
    begin
      @(negedge clk);
      check_idle_outputs();                      // Quiet until first request
    end
    for (d = 0; d < NUM_DUMPS; d++)
    begin
      @(posedge clk);
      dump_req <= 1'b1;
      drive_random_state();
      @(negedge clk);
      assert (busy === 1'b0) else mismatch("busy", busy, 0); // Fell after last done
      assert (done === 1'b0) else mismatch("done", done, 0);
      @(posedge clk);
      dump_req <= 1'b0;
      drive_random_state();                      // Held during the capture cycle
      push_expected_frame();
      got_done = 1'b0;
      while (!got_done)
      begin
        @(negedge clk);
        assert (busy === 1'b1) else mismatch("busy", busy, 1);
        got_done = done;
        if (!got_done)
        begin
          @(posedge clk);
          drive_random_state();                  // Inputs keep moving after capture
          dump_req <= ($urandom_range(0, 7) == 0); // Requests while busy are dropped
        end
      end
    end
    @(posedge clk);
    dump_req <= 1'b0;
    repeat (20 * `DBG_BIT_CYCLES)
    begin
      @(negedge clk);
      check_idle_outputs();                      // No extra frame starts
    end
    assert (rx_count == NUM_DUMPS * `DBG_FRAME_LEN)
      else mismatch("rx_count", rx_count, NUM_DUMPS * `DBG_FRAME_LEN);
    assert (done_count == NUM_DUMPS) else mismatch("done_count", done_count, NUM_DUMPS);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
design/dbg_pkg.sv
design/dbg_snapshot_buf.sv
design/dbg_uart_tx.sv
design/dbg_dump_ctrl.sv
design/dbg_dump_top.sv
bench/dbg_dump_tb.sv

/* Bender.yml */
package:
  name: dbg_dump

sources:
  - include_dirs:
      - include
    files:
      - design/dbg_pkg.sv
      - design/dbg_snapshot_buf.sv
      - design/dbg_uart_tx.sv
      - design/dbg_dump_ctrl.sv
      - design/dbg_dump_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/dbg_dump_tb.sv
